// File: logic/serdes_pkg.sv
// SERDES link shared definitions
`default_nettype none

package serdes_pkg;

   // Lane and stream widths
   localparam int lane_w = 16;
   localparam int stream_w = 32;

   // FIFO depth as log2, 512 entries
   localparam int fifo_aw = 9;

   // Wait count load after the CRC word, gives 16 idle words
   localparam logic [3:0] gap_len = 4'd15;

   // Control symbols
   // K28.5 comma
   localparam logic [7:0] k_comma = 8'hBC;
   // K28.6 frame start
   localparam logic [7:0] k_pkt_start = 8'hDC;
   // K28.4 frame end
   localparam logic [7:0] k_pkt_end = 8'h9C;
   // K28.2 and K28.3 flow-control ordered sets
   localparam logic [7:0] k_xon = 8'h5C;
   localparam logic [7:0] k_xoff = 8'h7C;

   // D5.6 filler that pairs with the comma on idle
   localparam logic [7:0] d_56 = 8'hC5;

   // CRC start value
   localparam logic [15:0] crc_init = 16'hFFFF;

endpackage

`default_nettype wire

// File: logic/serdes_fifo.sv
// Synchronous stream FIFO
`timescale 1ns/100ps
`default_nettype none

module serdes_fifo
#(
   parameter int aw = serdes_pkg::fifo_aw
)
(
   input  logic        clk,
   input  logic        rst,
   input  logic [33:0] din_i,
   input  logic        wr_i,
   output logic        full_o,
   output logic [33:0] dout_o,
   input  logic        rd_i,
   output logic        empty_o,
   output logic [15:0] occupied_o
);

   logic [33:0] mem [0:(1 << aw) - 1];
   logic [aw-1:0] wr_ptr;
   logic [aw-1:0] rd_ptr;
   logic [aw:0] count;
   logic do_wr;
   logic do_rd;

   // Writes dropped when full, reads dropped when empty
   assign do_wr = wr_i & ~full_o;
   assign do_rd = rd_i & ~empty_o;

   // Count reaches 2**aw only when every entry holds data
   assign full_o = count[aw];
   assign empty_o = (count == '0);
   assign occupied_o = {{(15 - aw){1'b0}}, count};

   // Head entry always visible
   assign dout_o = mem[rd_ptr];

   always_ff @(posedge clk)
   begin
      if (do_wr)
      begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (do_wr && !do_rd)
         begin
            count <= count + 1'b1;
         end
         else if (do_rd && !do_wr)
         begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/serdes_crc16.sv
// CRC-16 CCITT next-state logic
`timescale 1ns/100ps
`default_nettype none

module serdes_crc16
(
   input  logic [15:0] data_i,
   input  logic [15:0] crc_i,
   output logic [15:0] crc_o
);

   // x^16 + x^12 + x^5 + 1, one data bit per iteration, MSB first
   always_comb
   begin
      logic [15:0] c;
      logic fb;
      integer i;
      c = crc_i;
      for (i = 15; i >= 0; i = i - 1)
      begin
         fb = c[15] ^ data_i[i];
         c = {c[14:0], 1'b0};
         if (fb)
         begin
            c = c ^ 16'h1021;
         end
      end
      crc_o = c;
   end

endmodule

`default_nettype wire

// File: logic/serdes_tx.sv
// SERDES transmit framer
`timescale 1ns/100ps
`default_nettype none

module serdes_tx
(
   input  logic                          clk,
   input  logic                          rst,
   input  logic [serdes_pkg::stream_w-1:0] rd_dat_i,
   input  logic                          rd_sop_i,
   input  logic                          rd_eop_i,
   output logic                          rd_read_o,
   input  logic                          inhibit_tx_i,
   input  logic                          send_xon_i,
   input  logic                          send_xoff_i,
   output logic                          sent_o,
   output logic [serdes_pkg::lane_w-1:0] ser_t_o,
   output logic [1:0]                    ser_tk_o,
   output logic [15:0]                   fifo_occupied_o,
   output logic                          fifo_full_o,
   output logic                          fifo_empty_o
);

   localparam logic [2:0] st_idle = 3'd0;
   localparam logic [2:0] st_run1 = 3'd1;
   localparam logic [2:0] st_run2 = 3'd2;
   localparam logic [2:0] st_done = 3'd3;
   localparam logic [2:0] st_send_crc = 3'd4;
   localparam logic [2:0] st_wait_gap = 3'd5;

   logic [2:0] state;
   logic [3:0] wait_count;
   logic xfer_active;
   logic fifo_wr;
   logic fifo_rd;
   logic [serdes_pkg::stream_w+1:0] head;
   logic head_sop;
   logic head_eop;
   logic [serdes_pkg::stream_w-1:0] head_dat;
   logic send_flow;
   logic lo_send;
   logic hi_send;
   logic [15:0] crc;
   logic [15:0] crc_next;
   logic [15:0] crc_data;

   serdes_fifo #(.aw(serdes_pkg::fifo_aw)) fifo_inst
   (
      .clk        (clk),
      .rst        (rst),
      .din_i      ({rd_sop_i, rd_eop_i, rd_dat_i}),
      .wr_i       (fifo_wr),
      .full_o     (fifo_full_o),
      .dout_o     (head),
      .rd_i       (fifo_rd),
      .empty_o    (fifo_empty_o),
      .occupied_o (fifo_occupied_o)
   );

   assign head_sop = head[serdes_pkg::stream_w+1];
   assign head_eop = head[serdes_pkg::stream_w];
   assign head_dat = head[serdes_pkg::stream_w-1:0];

   // Capture window opens after sop and closes once eop is stored
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         xfer_active <= 1'b0;
      end
      else if (fifo_wr && rd_eop_i)
      begin
         xfer_active <= 1'b0;
      end
      else if (rd_sop_i)
      begin
         xfer_active <= 1'b1;
      end
   end

   assign fifo_wr = xfer_active & ~fifo_full_o;
   assign rd_read_o = fifo_wr;

   // Ordered sets preempt the lane for one cycle
   assign send_flow = send_xon_i | send_xoff_i;
   assign sent_o = send_flow;

   assign lo_send = (state == st_run1) & ~fifo_empty_o & ~inhibit_tx_i & ~send_flow;
   assign hi_send = (state == st_run2) & ~send_flow;

   // Pop after the high half, or drop stray non-sop heads while idle
   assign fifo_rd = hi_send | ((state == st_idle) & ~fifo_empty_o & ~head_sop);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= st_idle;
         wait_count <= '0;
         ser_t_o <= '0;
         ser_tk_o <= '0;
      end
      else if (send_xon_i)
      begin
         ser_tk_o <= 2'b11;
         ser_t_o <= {serdes_pkg::k_xon, serdes_pkg::k_xon};
      end
      else if (send_xoff_i)
      begin
         ser_tk_o <= 2'b11;
         ser_t_o <= {serdes_pkg::k_xoff, serdes_pkg::k_xoff};
      end
      else
      begin
         // Idle filler unless a state below overrides it
         ser_tk_o <= 2'b10;
         ser_t_o <= {serdes_pkg::k_comma, serdes_pkg::d_56};
         case (state)
            st_idle:
            begin
               if (head_sop && !fifo_empty_o && !inhibit_tx_i)
               begin
                  ser_tk_o <= 2'b11;
                  ser_t_o <= {serdes_pkg::k_pkt_start, serdes_pkg::k_pkt_start};
                  state <= st_run1;
               end
            end
            st_run1:
            begin
               if (lo_send)
               begin
                  ser_tk_o <= 2'b00;
                  ser_t_o <= head_dat[serdes_pkg::lane_w-1:0];
                  state <= st_run2;
               end
            end
            st_run2:
            begin
               ser_tk_o <= 2'b00;
               ser_t_o <= head_dat[serdes_pkg::stream_w-1:serdes_pkg::lane_w];
               state <= head_eop ? st_done : st_run1;
            end
            st_done:
            begin
               ser_tk_o <= 2'b11;
               ser_t_o <= {serdes_pkg::k_pkt_end, serdes_pkg::k_pkt_end};
               state <= st_send_crc;
            end
            st_send_crc:
            begin
               ser_tk_o <= 2'b00;
               ser_t_o <= crc;
               wait_count <= serdes_pkg::gap_len;
               state <= st_wait_gap;
            end
            st_wait_gap:
            begin
               if (wait_count == '0)
               begin
                  state <= st_idle;
               end
               else
               begin
                  wait_count <= wait_count - 1'b1;
               end
            end
            default:
            begin
               state <= st_idle;
            end
         endcase
      end
   end

   // Running CRC over every data half put on the lane
   assign crc_data = (state == st_run1) ? head_dat[serdes_pkg::lane_w-1:0]
                                        : head_dat[serdes_pkg::stream_w-1:serdes_pkg::lane_w];

   serdes_crc16 crc_inst
   (
      .data_i (crc_data),
      .crc_i  (crc),
      .crc_o  (crc_next)
   );

   always_ff @(posedge clk)
   begin
      if (rst || state == st_idle)
      begin
         crc <= serdes_pkg::crc_init;
      end
      else if (lo_send || hi_send)
      begin
         crc <= crc_next;
      end
   end

endmodule

`default_nettype wire

// File: logic/serdes_rx.sv
// SERDES receive deframer
`timescale 1ns/100ps
`default_nettype none

module serdes_rx
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic [serdes_pkg::lane_w-1:0]   ser_t_i,
   input  logic [1:0]                      ser_tk_i,
   output logic [serdes_pkg::stream_w-1:0] wr_dat_o,
   output logic                            wr_sop_o,
   output logic                            wr_eop_o,
   output logic                            wr_valid_o,
   output logic                            crc_ok_o,
   output logic                            crc_err_o,
   output logic                            rx_xon_o,
   output logic                            rx_xoff_o
);

   logic is_start;
   logic is_end;
   logic is_xon;
   logic is_xoff;
   logic is_data;
   logic in_frame;
   logic crc_pending;
   logic half_valid;
   logic [serdes_pkg::lane_w-1:0] low_half;
   logic held_valid;
   logic held_sop;
   logic [serdes_pkg::stream_w-1:0] held_dat;
   logic next_sop;
   logic [15:0] crc;
   logic [15:0] crc_next;

   // Symbol decode, both bytes must carry the same K code
   assign is_start = (ser_tk_i == 2'b11) &&
                     (ser_t_i == {serdes_pkg::k_pkt_start, serdes_pkg::k_pkt_start});
   assign is_end = (ser_tk_i == 2'b11) &&
                   (ser_t_i == {serdes_pkg::k_pkt_end, serdes_pkg::k_pkt_end});
   assign is_xon = (ser_tk_i == 2'b11) &&
                   (ser_t_i == {serdes_pkg::k_xon, serdes_pkg::k_xon});
   assign is_xoff = (ser_tk_i == 2'b11) &&
                    (ser_t_i == {serdes_pkg::k_xoff, serdes_pkg::k_xoff});
   assign is_data = (ser_tk_i == 2'b00);

   serdes_crc16 crc_inst
   (
      .data_i (ser_t_i),
      .crc_i  (crc),
      .crc_o  (crc_next)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         in_frame <= 1'b0;
         crc_pending <= 1'b0;
         half_valid <= 1'b0;
         held_valid <= 1'b0;
         next_sop <= 1'b0;
         wr_valid_o <= 1'b0;
         crc_ok_o <= 1'b0;
         crc_err_o <= 1'b0;
         rx_xon_o <= 1'b0;
         rx_xoff_o <= 1'b0;
      end
      else
      begin
         wr_valid_o <= 1'b0;
         crc_ok_o <= 1'b0;
         crc_err_o <= 1'b0;
         rx_xon_o <= is_xon;
         rx_xoff_o <= is_xoff;
         if (is_start)
         begin
            in_frame <= 1'b1;
            crc_pending <= 1'b0;
            half_valid <= 1'b0;
            held_valid <= 1'b0;
            next_sop <= 1'b1;
            crc <= serdes_pkg::crc_init;
         end
         else if (is_end && in_frame)
         begin
            // Held word is the last one of the frame
            in_frame <= 1'b0;
            crc_pending <= 1'b1;
            held_valid <= 1'b0;
            if (held_valid)
            begin
               wr_valid_o <= 1'b1;
               wr_dat_o <= held_dat;
               wr_sop_o <= held_sop;
               wr_eop_o <= 1'b1;
            end
         end
         else if (is_data && crc_pending)
         begin
            crc_pending <= 1'b0;
            crc_ok_o <= (ser_t_i == crc);
            crc_err_o <= (ser_t_i != crc);
         end
         else if (is_data && in_frame)
         begin
            crc <= crc_next;
            if (!half_valid)
            begin
               low_half <= ser_t_i;
               half_valid <= 1'b1;
            end
            else
            begin
               // Word complete, release the previous one
               half_valid <= 1'b0;
               if (held_valid)
               begin
                  wr_valid_o <= 1'b1;
                  wr_dat_o <= held_dat;
                  wr_sop_o <= held_sop;
                  wr_eop_o <= 1'b0;
               end
               held_dat <= {ser_t_i, low_half};
               held_sop <= next_sop;
               held_valid <= 1'b1;
               next_sop <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/serdes_link_top.sv
// SERDES loopback link
`timescale 1ns/100ps
`default_nettype none

module serdes_link_top
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic [serdes_pkg::stream_w-1:0] rd_dat_i,
   input  logic                            rd_sop_i,
   input  logic                            rd_eop_i,
   output logic                            rd_read_o,
   input  logic                            inhibit_tx_i,
   input  logic                            send_xon_i,
   input  logic                            send_xoff_i,
   output logic                            sent_o,
   output logic [15:0]                     fifo_occupied_o,
   output logic                            fifo_full_o,
   output logic                            fifo_empty_o,
   output logic [serdes_pkg::stream_w-1:0] wr_dat_o,
   output logic                            wr_sop_o,
   output logic                            wr_eop_o,
   output logic                            wr_valid_o,
   output logic                            crc_ok_o,
   output logic                            crc_err_o,
   output logic                            rx_xon_o,
   output logic                            rx_xoff_o,
   output logic [serdes_pkg::lane_w-1:0]   ser_t_o,
   output logic [1:0]                      ser_tk_o
);

   // Lane between framer and deframer
   logic [serdes_pkg::lane_w-1:0] ser_t;
   logic [1:0] ser_tk;

   assign ser_t_o = ser_t;
   assign ser_tk_o = ser_tk;

   serdes_tx tx_inst
   (
      .clk             (clk),
      .rst             (rst),
      .rd_dat_i        (rd_dat_i),
      .rd_sop_i        (rd_sop_i),
      .rd_eop_i        (rd_eop_i),
      .rd_read_o       (rd_read_o),
      .inhibit_tx_i    (inhibit_tx_i),
      .send_xon_i      (send_xon_i),
      .send_xoff_i     (send_xoff_i),
      .sent_o          (sent_o),
      .ser_t_o         (ser_t),
      .ser_tk_o        (ser_tk),
      .fifo_occupied_o (fifo_occupied_o),
      .fifo_full_o     (fifo_full_o),
      .fifo_empty_o    (fifo_empty_o)
   );

   serdes_rx rx_inst
   (
      .clk        (clk),
      .rst        (rst),
      .ser_t_i    (ser_t),
      .ser_tk_i   (ser_tk),
      .wr_dat_o   (wr_dat_o),
      .wr_sop_o   (wr_sop_o),
      .wr_eop_o   (wr_eop_o),
      .wr_valid_o (wr_valid_o),
      .crc_ok_o   (crc_ok_o),
      .crc_err_o  (crc_err_o),
      .rx_xon_o   (rx_xon_o),
      .rx_xoff_o  (rx_xoff_o)
   );

endmodule

`default_nettype wire

// File: verif/serdes_link_tb.sv
// Loopback link testbench
`timescale 1ns/100ps
`default_nettype none

module serdes_link_tb;

   // K28.5 comma over D5.6 on an idle lane
   localparam logic [15:0] idle_word = 16'hBCC5;
   localparam int fifo_depth = 512;

   logic clk = 1'b0;
   logic rst;
   logic [31:0] rd_dat_i;
   logic rd_sop_i;
   logic rd_eop_i;
   logic rd_read_o;
   logic inhibit_tx_i;
   logic send_xon_i;
   logic send_xoff_i;
   logic sent_o;
   logic [15:0] fifo_occupied_o;
   logic fifo_full_o;
   logic fifo_empty_o;
   logic [31:0] wr_dat_o;
   logic wr_sop_o;
   logic wr_eop_o;
   logic wr_valid_o;
   logic crc_ok_o;
   logic crc_err_o;
   logic rx_xon_o;
   logic rx_xoff_o;
   logic [15:0] ser_t_o;
   logic [1:0] ser_tk_o;

   integer seed = 36;
   string test_name = "reset";
   // Words still in flight as {sop, eop, data}
   logic [33:0] exp_q [$];
   logic [33:0] expected_word;
   int accept_count = 0;
   int rx_word_count = 0;
   int crc_ok_count = 0;
   int xon_count = 0;
   int xoff_count = 0;
   int ok_base;
   int len;
   int n;

   serdes_link_top serdes_link_top_inst
   (
      .clk             (clk),
      .rst             (rst),
      .rd_dat_i        (rd_dat_i),
      .rd_sop_i        (rd_sop_i),
      .rd_eop_i        (rd_eop_i),
      .rd_read_o       (rd_read_o),
      .inhibit_tx_i    (inhibit_tx_i),
      .send_xon_i      (send_xon_i),
      .send_xoff_i     (send_xoff_i),
      .sent_o          (sent_o),
      .fifo_occupied_o (fifo_occupied_o),
      .fifo_full_o     (fifo_full_o),
      .fifo_empty_o    (fifo_empty_o),
      .wr_dat_o        (wr_dat_o),
      .wr_sop_o        (wr_sop_o),
      .wr_eop_o        (wr_eop_o),
      .wr_valid_o      (wr_valid_o),
      .crc_ok_o        (crc_ok_o),
      .crc_err_o       (crc_err_o),
      .rx_xon_o        (rx_xon_o),
      .rx_xoff_o       (rx_xoff_o),
      .ser_t_o         (ser_t_o),
      .ser_tk_o        (ser_tk_o)
   );

   always
   begin
      #20 clk = ~clk;
   end

   task automatic stop_run;
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected)
      else
      begin
         $display("ERROR: test %s, %s expected 0x%0h actual 0x%0h",
                  test_name, what, expected, actual);
         stop_run();
      end
   endtask

   task automatic report_timeout(input string reason);
      $display("Timeout in test %s: %s", test_name, reason);
      stop_run();
   endtask

   task automatic wait_cycles(input int cycles);
      repeat (cycles) @(posedge clk);
   endtask

   // Stream source that holds each word until the framer reads it
   task automatic send_packet(input int words);
      int i;
      int cycles;
      logic [31:0] dat;
      for (i = 0; i < words; i = i + 1)
      begin
         dat = $random(seed);
         @(posedge clk);
         rd_dat_i <= dat;
         rd_sop_i <= (i == 0);
         rd_eop_i <= (i == words - 1);
         cycles = 0;
         @(negedge clk);
         while (!rd_read_o)
         begin
            cycles = cycles + 1;
            if (cycles > 1000)
            begin
               report_timeout("stream word was never read by the framer");
            end
            @(negedge clk);
         end
         exp_q.push_back({i == 0, i == words - 1, dat});
         accept_count = accept_count + 1;
      end
      @(posedge clk);
      rd_sop_i <= 1'b0;
      rd_eop_i <= 1'b0;
   endtask

   task automatic wait_drained(input int ok_target, input int limit);
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (exp_q.size() != 0 || crc_ok_count != ok_target)
      begin
         cycles = cycles + 1;
         if (cycles > limit)
         begin
            report_timeout("packets did not drain through the link");
         end
         @(posedge clk);
      end
   endtask

   task automatic pulse_flow(input logic xon);
      @(posedge clk);
      send_xon_i <= xon;
      send_xoff_i <= ~xon;
      @(negedge clk);
      check_value("sent_o", 64'd1, 64'(sent_o));
      @(posedge clk);
      send_xon_i <= 1'b0;
      send_xoff_i <= 1'b0;
   endtask

   // Receive side monitor
   always @(negedge clk)
   begin
      if (!rst)
      begin
         if (wr_valid_o)
         begin
            assert (exp_q.size() > 0)
            begin
               expected_word = exp_q.pop_front();
               rx_word_count = rx_word_count + 1;
               check_value("received {sop,eop,data}", 64'(expected_word),
                           64'({wr_sop_o, wr_eop_o, wr_dat_o}));
            end
            else
            begin
               $display("Test %s: receiver produced a word that was never sent", test_name);
               stop_run();
            end
         end
         check_value("crc_err_o", 64'd0, 64'(crc_err_o));
         if (fifo_full_o)
         begin
            check_value("rd_read_o while FIFO full", 64'd0, 64'(rd_read_o));
         end
         if (crc_ok_o)
            crc_ok_count = crc_ok_count + 1;
         if (rx_xon_o)
            xon_count = xon_count + 1;
         if (rx_xoff_o)
            xoff_count = xoff_count + 1;
      end
   end

   initial
   begin
      rst = 1'b1;
      rd_dat_i = '0;
      rd_sop_i = 1'b0;
      rd_eop_i = 1'b0;
      inhibit_tx_i = 1'b0;
      send_xon_i = 1'b0;
      send_xoff_i = 1'b0;
      wait_cycles(3);
      rst <= 1'b0;

      // Lane is zero for one cycle, then idle
      test_name = "idle";
      wait_cycles(2);
      repeat (20)
      begin
         @(negedge clk);
         check_value("ser_tk_o", 64'd2, 64'(ser_tk_o));
         check_value("ser_t_o", 64'(idle_word), 64'(ser_t_o));
         check_value("fifo_empty_o", 64'd1, 64'(fifo_empty_o));
      end
      wait_cycles(1);
      check_value("receive pulses", 64'd0,
                  64'(rx_word_count + crc_ok_count + xon_count + xoff_count));

      test_name = "single";
      ok_base = crc_ok_count;
      len = 1 + ($unsigned($random(seed)) % 8);
      send_packet(len);
      wait_drained(ok_base + 1, 500);
      wait_cycles(30);
      check_value("crc_ok pulses", 64'(ok_base + 1), 64'(crc_ok_count));

      test_name = "back_to_back";
      ok_base = crc_ok_count;
      repeat (20)
      begin
         len = 1 + ($unsigned($random(seed)) % 8);
         send_packet(len);
      end
      wait_drained(ok_base + 20, 2000);
      wait_cycles(30);
      check_value("crc_ok pulses", 64'(ok_base + 20), 64'(crc_ok_count));

      test_name = "inhibit";
      ok_base = crc_ok_count;
      n = rx_word_count;
      @(posedge clk);
      inhibit_tx_i <= 1'b1;
      accept_count = 0;
      len = 1 + ($unsigned($random(seed)) % 8);
      send_packet(len);
      wait_cycles(40);
      check_value("words received while inhibited", 64'(n), 64'(rx_word_count));
      check_value("fifo_occupied_o", 64'(accept_count), 64'(fifo_occupied_o));
      @(posedge clk);
      inhibit_tx_i <= 1'b0;
      wait_drained(ok_base + 1, 500);
      wait_cycles(30);

      // Ordered sets land while the framer is still sending data
      test_name = "flow";
      ok_base = crc_ok_count;
      send_packet(8);
      pulse_flow(1'b1);
      wait_cycles(3);
      pulse_flow(1'b0);
      wait_drained(ok_base + 1, 500);
      wait_cycles(30);
      check_value("rx_xon pulses", 64'd1, 64'(xon_count));
      check_value("rx_xoff pulses", 64'd1, 64'(xoff_count));
      check_value("crc_ok pulses", 64'(ok_base + 1), 64'(crc_ok_count));

      test_name = "backpressure";
      ok_base = crc_ok_count;
      @(posedge clk);
      inhibit_tx_i <= 1'b1;
      accept_count = 0;
      fork
         send_packet(fifo_depth + 8);
         begin
            n = 0;
            @(negedge clk);
            while (!fifo_full_o)
            begin
               n = n + 1;
               if (n > 2000)
               begin
                  report_timeout("FIFO never reported full");
               end
               @(negedge clk);
            end
            check_value("words accepted at full", 64'(fifo_depth), 64'(accept_count));
            check_value("fifo_occupied_o at full", 64'(fifo_depth), 64'(fifo_occupied_o));
            repeat (20)
            begin
               @(negedge clk);
               check_value("fifo_full_o while held", 64'd1, 64'(fifo_full_o));
            end
            @(posedge clk);
            inhibit_tx_i <= 1'b0;
         end
      join
      wait_drained(ok_base + 1, 3000);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
logic/serdes_pkg.sv
logic/serdes_fifo.sv
logic/serdes_crc16.sv
logic/serdes_tx.sv
logic/serdes_rx.sv
logic/serdes_link_top.sv
verif/serdes_link_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the loopback link testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f src.f --top-module serdes_link_tb > sim.log 2>&1 &&
./obj_dir/Vserdes_link_tb >> sim.log 2>&1 ||
echo "TESTBENCH FAILED" >> sim.log

cat sim.log
! grep -q "TESTBENCH FAILED" sim.log
